/* hw/vcu_pkg.sv */
// vector control unit package with instruction classes, ALU opmodes and vtype layout
`default_nettype none

package vcu_pkg;

   localparam int VREG_IDX_W = 5;    // vector register index
   localparam int INSTR_W    = 32;   // instruction word and scalar operand

   localparam logic [2:0] RESET_SEW = 3'b010;   // 32-bit elements

   // instruction class presented by the scheduler
   typedef enum logic [2:0] {
      OPIVV = 3'd0,
      OPIVI = 3'd1,
      OPIVX = 3'd2,
      OPMVV = 3'd3,
      OPMVX = 3'd4,
      CFG   = 3'd5
   } instr_class_e;

   // upper bits group the opmodes by ALU unit
   typedef enum logic [8:0] {
      ALU_NOP       = 9'h000,
      ALU_ADD       = 9'h040,
      ALU_ADDU      = 9'h041,
      ALU_SUB       = 9'h042,
      ALU_SUBU      = 9'h043,
      ALU_SLT       = 9'h080,
      ALU_SLTU      = 9'h081,
      ALU_SLE       = 9'h082,
      ALU_SLEU      = 9'h083,
      ALU_SGT       = 9'h084,
      ALU_SGTU      = 9'h085,
      ALU_SEQ       = 9'h086,
      ALU_SNEQ      = 9'h087,
      ALU_AND       = 9'h0c0,
      ALU_OR        = 9'h0c1,
      ALU_XOR       = 9'h0c2,
      ALU_ANDNOT    = 9'h0c3,
      ALU_ORNOT     = 9'h0c4,
      ALU_NAND      = 9'h0c5,
      ALU_NOR       = 9'h0c6,
      ALU_XNOR      = 9'h0c7,
      ALU_SLL       = 9'h100,
      ALU_SRL       = 9'h101,
      ALU_SRA       = 9'h102,
      ALU_MUL       = 9'h140,
      ALU_MULU      = 9'h141,
      ALU_MULSU     = 9'h142,
      ALU_MULH      = 9'h143,
      ALU_MULHU     = 9'h144,
      ALU_MULHSU    = 9'h145,
      ALU_MUL_ADD   = 9'h180,
      ALU_MULU_ADD  = 9'h181,
      ALU_MULSU_ADD = 9'h182,
      ALU_MULUS_ADD = 9'h183,
      ALU_MUL_SUB   = 9'h184
   } alu_op_e;

   // operand 2 source of the ALU
   typedef enum logic [1:0] {
      VECTOR = 2'b00,
      SCALAR = 2'b01,
      IMM    = 2'b10,
      NONE   = 2'b11
   } op2_sel_e;

   typedef struct packed {
      logic        ill;        // illegal configuration
      logic [22:0] reserved;
      logic        ma;         // mask agnostic
      logic        ta;         // tail agnostic
      logic [2:0]  sew;
      logic [2:0]  lmul;
   } vtype_t;

endpackage

`default_nettype wire

/* hw/vcu_issue_if.sv */
// issue interface carrying a decoded arithmetic instruction to the launch logic
`timescale 1ns/1ns
`default_nettype none

interface vcu_issue_if
   import vcu_pkg::*;
();

   logic                  issue_vld;   // arithmetic instruction waiting
   logic [VREG_IDX_W-1:0] vd;
   logic [VREG_IDX_W-1:0] vs1;
   logic [VREG_IDX_W-1:0] vs2;
   logic                  vv;          // vs1 is a vector source
   alu_op_e               opmode;
   op2_sel_e              op2_sel;
   logic [INSTR_W-1:0]    x_data;
   logic [VREG_IDX_W-1:0] imm;
   logic                  issue_fire;  // launched this cycle

   modport decoder (
      output issue_vld, vd, vs1, vs2, vv, opmode, op2_sel, x_data, imm
   );

   modport issuer (
      input  issue_vld, vd, vs1, vs2, vv, opmode, op2_sel, x_data, imm,
      output issue_fire
   );

endinterface

`default_nettype wire

/* hw/instr_capture.sv */
// instruction holding register with the scheduler valid/ready handshake
`timescale 1ns/1ns
`default_nettype none

module instr_capture
   import vcu_pkg::*;
(
   input  logic               clk,
   input  logic               rstn,
   input  logic               instr_vld_i,
   input  instr_class_e       instr_class_i,
   input  logic [INSTR_W-1:0] vector_instr_i,
   input  logic [INSTR_W-1:0] scalar_rs1_i,
   input  logic [INSTR_W-1:0] scalar_rs2_i,
   input  logic               release_i,
   output logic               instr_rdy_o,
   output logic               held_vld_o,
   output instr_class_e       held_class_o,
   output logic [INSTR_W-1:0] held_instr_o,
   output logic [INSTR_W-1:0] held_rs1_o
);

   logic held_release;   // holder empties on this edge
   logic accept;

   // config instructions retire after one cycle in the holder
   assign held_release = release_i || (held_vld_o && held_class_o == CFG);
   assign instr_rdy_o  = !held_vld_o || held_release;
   assign accept       = instr_vld_i && instr_rdy_o;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         held_vld_o <= 1'b0;
      end
      else if (accept)
      begin
         held_vld_o <= 1'b1;
      end
      else if (held_release)
      begin
         held_vld_o <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         held_class_o <= instr_class_i;
         held_instr_o <= vector_instr_i;
         held_rs1_o   <= scalar_rs1_i;
      end
   end

   // a held instruction only leaves through issue or config retirement
   a_hold_until_release : assert property (@(posedge clk) disable iff (!rstn)
      held_vld_o && !held_release |=> held_vld_o);

   // scheduler must present defined operands with each accepted instruction
   a_accept_known : assert property (@(posedge clk) disable iff (!rstn)
      accept |-> !$isunknown({instr_class_i, vector_instr_i, scalar_rs1_i, scalar_rs2_i}));

endmodule

`default_nettype wire

/* hw/vtype_config.sv */
// vtype and vl configuration registers with the vlmax lookup
`timescale 1ns/1ns
`default_nettype none

module vtype_config
   import vcu_pkg::*;
#(
   parameter int VLEN = 4096
)
(
   input  logic               clk,
   input  logic               rstn,
   input  logic               held_vld_i,
   input  instr_class_e       held_class_i,
   input  logic [INSTR_W-1:0] held_instr_i,
   input  logic [INSTR_W-1:0] held_rs1_i,
   output logic [2:0]         sew_o,
   output logic [2:0]         lmul_o,
   output logic [INSTR_W-1:0] vl_o
);

   typedef logic [7:0][7:0][INSTR_W-1:0] vlmax_tab_t;   // [lmul][sew]

   // lmul 4 and sew above 64 bits are reserved and stay zero
   function automatic vlmax_tab_t init_vlmax();
      vlmax_tab_t tab;
      tab = '0;
      for (int s = 0; s < 4; s++)
      begin
         for (int l = 0; l < 4; l++)
         begin
            tab[l][s] = INSTR_W'(((VLEN / 8) >> s) << l);
         end
         for (int l = 5; l < 8; l++)
         begin
            tab[l][s] = INSTR_W'(((VLEN / 8) >> s) >> (8 - l));   // fractional lmul
         end
      end
      return tab;
   endfunction

   localparam vlmax_tab_t VLMAX_TAB = init_vlmax();

   vtype_t             vtype_q;
   vtype_t             vtype_next;
   logic [INSTR_W-1:0] vl_q;
   logic [INSTR_W-1:0] vl_next;
   logic [INSTR_W-1:0] vlmax;
   logic               cfg_upd;

   assign cfg_upd = held_vld_i && held_class_i == CFG;

   always_comb
   begin
      vtype_next = '0;
      if (held_instr_i[31:30] != 2'b10)   // vsetvli form, vtype in the immediate
      begin
         vtype_next.lmul = held_instr_i[22:20];
         vtype_next.sew  = held_instr_i[25:23];
         vtype_next.ta   = held_instr_i[26];
         vtype_next.ma   = held_instr_i[27];
      end
      else
      begin
         vtype_next = vtype_t'(held_rs1_i);   // vsetvl form
      end
   end

   assign vlmax = VLMAX_TAB[vtype_next.lmul][vtype_next.sew];

   // rs1 field picks the scalar avl, otherwise vd field requests vlmax
   assign vl_next = (held_instr_i[19:15] != '0) ? held_rs1_i :
                    (held_instr_i[11:7] != '0)  ? vlmax : vl_q;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_q      <= '0;
         vtype_q.sew  <= RESET_SEW;
         vl_q         <= INSTR_W'(VLEN / 32);
      end
      else if (cfg_upd)
      begin
         vtype_q <= vtype_next;
         vl_q    <= vl_next;
      end
   end

   assign sew_o  = vtype_q.sew;
   assign lmul_o = vtype_q.lmul;
   assign vl_o   = vl_q;

endmodule

`default_nettype wire

/* hw/alu_op_decoder.sv */
// arithmetic instruction decoder from funct6 and class to ALU opmode and operands
`timescale 1ns/1ns
`default_nettype none

module alu_op_decoder
   import vcu_pkg::*;
(
   input  logic               held_vld_i,
   input  instr_class_e       held_class_i,
   input  logic [INSTR_W-1:0] held_instr_i,
   input  logic [INSTR_W-1:0] held_rs1_i,
   vcu_issue_if.decoder       iss
);

   // integer table shared by vv, vx and vi forms
   function automatic alu_op_e opi_op(input logic [5:0] f6);
      alu_op_e op;
      case (f6)
         6'b000000, 6'b010000, 6'b010001, 6'b100001: op = ALU_ADD;   // vadd, vadc, vmadc
         6'b000010, 6'b000011, 6'b010010, 6'b010011, 6'b100011: op = ALU_SUB;
         6'b000100, 6'b011010: op = ALU_SLTU;
         6'b000101, 6'b011011: op = ALU_SLT;
         6'b000110, 6'b011110: op = ALU_SGTU;
         6'b000111, 6'b011111: op = ALU_SGT;
         6'b001001: op = ALU_AND;
         6'b001010: op = ALU_OR;
         6'b001011: op = ALU_XOR;
         6'b011000: op = ALU_SEQ;
         6'b011001: op = ALU_SNEQ;
         6'b011100: op = ALU_SLEU;
         6'b011101: op = ALU_SLE;
         6'b100000: op = ALU_ADDU;   // saturating
         6'b100010: op = ALU_SUBU;
         6'b100101: op = ALU_SLL;
         6'b100111: op = ALU_MUL;
         6'b101000, 6'b101010, 6'b101100, 6'b101110, 6'b101111: op = ALU_SRL;
         6'b101001, 6'b101011, 6'b101101: op = ALU_SRA;   // incl. rounding and narrowing
         default: op = ALU_NOP;
      endcase
      return op;
   endfunction

   // mask logic, averaging, multiply and widening forms
   function automatic alu_op_e opm_op(input logic [5:0] f6);
      alu_op_e op;
      case (f6)
         6'b001000, 6'b110000, 6'b110100: op = ALU_ADDU;
         6'b001001, 6'b110001, 6'b110101: op = ALU_ADD;
         6'b001010, 6'b110010, 6'b110110: op = ALU_SUBU;
         6'b001011, 6'b110011, 6'b110111: op = ALU_SUB;
         6'b011000: op = ALU_ANDNOT;
         6'b011001: op = ALU_AND;
         6'b011010: op = ALU_OR;
         6'b011011: op = ALU_XOR;
         6'b011100: op = ALU_ORNOT;
         6'b011101: op = ALU_NAND;
         6'b011110: op = ALU_NOR;
         6'b011111: op = ALU_XNOR;
         6'b100100: op = ALU_MULHU;
         6'b100101, 6'b111011: op = ALU_MUL;
         6'b100110: op = ALU_MULHSU;
         6'b100111: op = ALU_MULH;
         6'b101001, 6'b101101, 6'b111101: op = ALU_MUL_ADD;   // vmadd, vmacc, vwmacc
         6'b101011, 6'b101111: op = ALU_MUL_SUB;
         6'b111000: op = ALU_MULU;
         6'b111010: op = ALU_MULSU;
         6'b111100: op = ALU_MULU_ADD;
         6'b111110: op = ALU_MULUS_ADD;
         6'b111111: op = ALU_MULSU_ADD;
         default: op = ALU_NOP;
      endcase
      return op;
   endfunction

   logic [5:0] funct6;

   assign funct6 = held_instr_i[31:26];

   always_comb
   begin
      case (held_class_i)
         OPIVV, OPIVX, OPIVI: iss.opmode = opi_op(funct6);
         OPMVV, OPMVX:        iss.opmode = opm_op(funct6);
         default:             iss.opmode = ALU_NOP;
      endcase
   end

   always_comb
   begin
      case (held_class_i)
         OPIVV, OPMVV: iss.op2_sel = VECTOR;
         OPIVX, OPMVX: iss.op2_sel = SCALAR;
         OPIVI:        iss.op2_sel = IMM;
         default:      iss.op2_sel = NONE;
      endcase
   end

   assign iss.issue_vld = held_vld_i && held_class_i != CFG;
   assign iss.vv        = held_class_i == OPIVV || held_class_i == OPMVV;
   assign iss.vd        = held_instr_i[11:7];
   assign iss.vs1       = held_instr_i[19:15];
   assign iss.vs2       = held_instr_i[24:20];
   assign iss.imm       = held_instr_i[19:15];   // same field as vs1
   assign iss.x_data    = held_rs1_i;

endmodule

`default_nettype wire

/* hw/port_allocator.sv */
// write-port group allocator picking the lowest ready group for each launch
`timescale 1ns/1ns
`default_nettype none

module port_allocator
   import vcu_pkg::*;
#(
   parameter int PORT_GROUPS = 4
)
(
   input  logic [PORT_GROUPS-1:0] port_group_ready_i,
   input  logic                   stall_i,
   vcu_issue_if.issuer            iss,
   output logic [PORT_GROUPS-1:0] start_o
);

   logic [PORT_GROUPS-1:0] lowest_rdy;
   logic                   any_rdy;
   logic                   fire;

   // isolate the lowest set bit of the ready mask
   assign lowest_rdy = port_group_ready_i & (~port_group_ready_i + 1'b1);
   assign any_rdy    = |port_group_ready_i;

   assign fire = iss.issue_vld && !stall_i && any_rdy;

   assign start_o        = fire ? lowest_rdy : '0;
   assign iss.issue_fire = fire;

endmodule

`default_nettype wire

/* hw/hazard_tracker.sv */
// read-after-write tracker holding in-flight destinations per port group
`timescale 1ns/1ns
`default_nettype none

module hazard_tracker
   import vcu_pkg::*;
#(
   parameter int PORT_GROUPS   = 4,
   parameter int HAZARD_CYCLES = 15
)
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [PORT_GROUPS-1:0] start_i,
   vcu_issue_if.issuer            iss,
   output logic                   stall_o
);

   localparam int CNT_W = $clog2(HAZARD_CYCLES + 1);

   logic [PORT_GROUPS-1:0][VREG_IDX_W-1:0] vd_q;    // destination per group
   logic [PORT_GROUPS-1:0][CNT_W-1:0]      cnt_q;   // zero means entry empty
   logic [PORT_GROUPS-1:0]                 hit;

   always_ff @(posedge clk)
   begin
      for (int g = 0; g < PORT_GROUPS; g++)
      begin
         if (!rstn)
         begin
            cnt_q[g] <= '0;
         end
         else if (start_i[g])
         begin
            cnt_q[g] <= CNT_W'(HAZARD_CYCLES);
         end
         else if (cnt_q[g] != '0)
         begin
            cnt_q[g] <= cnt_q[g] - 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int g = 0; g < PORT_GROUPS; g++)
      begin
         if (start_i[g])
         begin
            vd_q[g] <= iss.vd;
         end
      end
   end

   always_comb
   begin
      for (int g = 0; g < PORT_GROUPS; g++)
      begin
         hit[g] = cnt_q[g] != '0 &&
                  (vd_q[g] == iss.vs2 || (iss.vv && vd_q[g] == iss.vs1));
      end
   end

   assign stall_o = iss.issue_vld && |hit;

   // one destination recorded per launch
   a_start_onehot : assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(start_i));

   for (genvar g = 0; g < PORT_GROUPS; g++)
   begin : g_chk
      a_cnt_bound : assert property (@(posedge clk) disable iff (!rstn)
         cnt_q[g] <= CNT_W'(HAZARD_CYCLES));
   end

endmodule

`default_nettype wire

/* hw/vcu_top.sv */
// vector control unit top level connecting holder, config, decoder and issue logic
`timescale 1ns/1ns
`default_nettype none

module vcu_top
   import vcu_pkg::*;
#(
   parameter int VLEN          = 4096,
   parameter int PORT_GROUPS   = 4,
   parameter int HAZARD_CYCLES = 15
)
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   instr_vld_i,      // scheduler side
   input  instr_class_e           instr_class_i,
   input  logic [INSTR_W-1:0]     vector_instr_i,
   input  logic [INSTR_W-1:0]     scalar_rs1_i,
   input  logic [INSTR_W-1:0]     scalar_rs2_i,
   output logic                   instr_rdy_o,
   input  logic [PORT_GROUPS-1:0] port_group_ready_i,   // lane side
   output logic [PORT_GROUPS-1:0] start_o,
   output logic [2:0]             sew_o,
   output logic [2:0]             lmul_o,
   output logic [INSTR_W-1:0]     vl_o,
   output alu_op_e                alu_opmode_o,
   output op2_sel_e               op2_sel_o,
   output logic [INSTR_W-1:0]     alu_x_data_o,
   output logic [VREG_IDX_W-1:0]  alu_imm_o
);

   logic               held_vld;
   instr_class_e       held_class;
   logic [INSTR_W-1:0] held_instr;
   logic [INSTR_W-1:0] held_rs1;
   logic               stall;

   vcu_issue_if u_iss ();

   instr_capture u_instr_capture (
      .clk            (clk),
      .rstn           (rstn),
      .instr_vld_i    (instr_vld_i),
      .instr_class_i  (instr_class_i),
      .vector_instr_i (vector_instr_i),
      .scalar_rs1_i   (scalar_rs1_i),
      .scalar_rs2_i   (scalar_rs2_i),
      .release_i      (u_iss.issue_fire),
      .instr_rdy_o    (instr_rdy_o),
      .held_vld_o     (held_vld),
      .held_class_o   (held_class),
      .held_instr_o   (held_instr),
      .held_rs1_o     (held_rs1)
   );

   vtype_config #(.VLEN(VLEN)) u_vtype_config (
      .clk          (clk),
      .rstn         (rstn),
      .held_vld_i   (held_vld),
      .held_class_i (held_class),
      .held_instr_i (held_instr),
      .held_rs1_i   (held_rs1),
      .sew_o        (sew_o),
      .lmul_o       (lmul_o),
      .vl_o         (vl_o)
   );

   alu_op_decoder u_alu_op_decoder (
      .held_vld_i   (held_vld),
      .held_class_i (held_class),
      .held_instr_i (held_instr),
      .held_rs1_i   (held_rs1),
      .iss          (u_iss.decoder)
   );

   port_allocator #(.PORT_GROUPS(PORT_GROUPS)) u_port_allocator (
      .port_group_ready_i (port_group_ready_i),
      .stall_i            (stall),
      .iss                (u_iss.issuer),
      .start_o            (start_o)
   );

   hazard_tracker #(
      .PORT_GROUPS   (PORT_GROUPS),
      .HAZARD_CYCLES (HAZARD_CYCLES)
   ) u_hazard_tracker (
      .clk     (clk),
      .rstn    (rstn),
      .start_i (start_o),
      .iss     (u_iss.issuer),
      .stall_o (stall)
   );

   // ALU controls, valid while start_o is high
   assign alu_opmode_o = u_iss.opmode;
   assign op2_sel_o    = u_iss.op2_sel;
   assign alu_x_data_o = u_iss.x_data;
   assign alu_imm_o    = u_iss.imm;

endmodule

`default_nettype wire

/* testbench/tb_vcu.sv */
// testbench for the vector control unit, replaying config and arithmetic steps from a file
`timescale 1ns/1ns
`default_nettype none

module tb_vcu
   import vcu_pkg::*;
();

   localparam int VLEN          = 4096;
   localparam int PORT_GROUPS   = 4;
   localparam int HAZARD_CYCLES = 15;

   // one line of the stimulus file
   typedef struct packed {
      logic [31:0] cls;
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] mask;       // ready groups
      logic [31:0] delay;      // cycles with no group ready
      logic [31:0] exp_a;      // sew or opmode
      logic [31:0] exp_b;      // lmul or op2_sel
      logic [31:0] exp_c;      // vl or start
      logic [31:0] exp_wait;   // cycles from accept to start
   } step_t;

   logic                   clk;
   logic                   rstn;
   logic                   instr_vld_i;
   instr_class_e           instr_class_i;
   logic [31:0]            vector_instr_i;
   logic [31:0]            scalar_rs1_i;
   logic [31:0]            scalar_rs2_i;
   logic                   instr_rdy_o;
   logic [PORT_GROUPS-1:0] port_group_ready_i;
   logic [PORT_GROUPS-1:0] start_o;
   logic [2:0]             sew_o;
   logic [2:0]             lmul_o;
   logic [31:0]            vl_o;
   alu_op_e                alu_opmode_o;
   op2_sel_e               op2_sel_o;
   logic [31:0]            alu_x_data_o;
   logic [4:0]             alu_imm_o;

   step_t steps[$];
   int    fail_count  = 0;
   int    cycle_count = 0;
   int    cycle_limit = 0;   // zero until the file is loaded

   vcu_top #(
      .VLEN          (VLEN),
      .PORT_GROUPS   (PORT_GROUPS),
      .HAZARD_CYCLES (HAZARD_CYCLES)
   ) u_vcu_top (
      .clk                (clk),
      .rstn               (rstn),
      .instr_vld_i        (instr_vld_i),
      .instr_class_i      (instr_class_i),
      .vector_instr_i     (vector_instr_i),
      .scalar_rs1_i       (scalar_rs1_i),
      .scalar_rs2_i       (scalar_rs2_i),
      .instr_rdy_o        (instr_rdy_o),
      .port_group_ready_i (port_group_ready_i),
      .start_o            (start_o),
      .sew_o              (sew_o),
      .lmul_o             (lmul_o),
      .vl_o               (vl_o),
      .alu_opmode_o       (alu_opmode_o),
      .op2_sel_o          (op2_sel_o),
      .alu_x_data_o       (alu_x_data_o),
      .alu_imm_o          (alu_imm_o)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count > cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         fail_count++;
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f [9];
      fd = $fopen("testbench/vcu_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file testbench/vcu_stimulus.txt");
         $display("SOME TESTS FAILED");
         $fatal(1, "no stimulus");
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#")   // skip the column notes
            begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
               if (n == 9)
               begin
                  steps.push_back({f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]});
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // drive one instruction and wait until the DUT will take it on the next edge
   task automatic present_instr(input step_t s, input logic [PORT_GROUPS-1:0] mask);
      @(negedge clk);
      instr_vld_i        = 1'b1;
      instr_class_i      = instr_class_e'(s.cls[2:0]);
      vector_instr_i     = s.instr;
      scalar_rs1_i       = s.rs1;
      scalar_rs2_i       = ~s.rs1;
      port_group_ready_i = mask;
      #1;
      while (!instr_rdy_o)
      begin
         @(negedge clk);
         #1;
      end
   endtask

   task automatic run_config_step(input step_t s);
      present_instr(s, s.mask[PORT_GROUPS-1:0]);
      @(negedge clk);
      instr_vld_i = 1'b0;
      #1;
      check_value(start_o, '0, "start_o while config held");
      @(negedge clk);   // registers updated one edge after acceptance
      #1;
      check_value(sew_o, s.exp_a, "sew_o");
      check_value(lmul_o, s.exp_b, "lmul_o");
      check_value(vl_o, s.exp_c, "vl_o");
      check_value(instr_rdy_o, 1'b1, "instr_rdy_o after config");
   endtask

   task automatic run_arith_step(input step_t s);
      int   waited;
      logic launched;
      waited   = 0;
      launched = 1'b0;
      present_instr(s, (s.delay == 0) ? s.mask[PORT_GROUPS-1:0] : {PORT_GROUPS{1'b0}});
      while (!launched)
      begin
         @(negedge clk);
         instr_vld_i = 1'b0;
         if (waited >= s.delay)
         begin
            port_group_ready_i = s.mask[PORT_GROUPS-1:0];
         end
         #1;
         if (start_o != '0)
         begin
            launched = 1'b1;
            check_value(waited, s.exp_wait, "cycles from accept to start");
            check_value(start_o, s.exp_c, "start_o");
            check_value(alu_opmode_o, s.exp_a, "alu_opmode_o");
            check_value(op2_sel_o, s.exp_b, "op2_sel_o");
            check_value(alu_x_data_o, s.rs1, "alu_x_data_o");
            check_value(alu_imm_o, s.instr[19:15], "alu_imm_o");
         end
         else
         begin
            check_value(instr_rdy_o, 1'b0, "instr_rdy_o while waiting to start");
            waited++;
         end
      end
   endtask

   initial
   begin
      clk                = 1'b0;
      rstn               = 1'b0;
      instr_vld_i        = 1'b0;
      instr_class_i      = OPIVV;
      vector_instr_i     = '0;
      scalar_rs1_i       = '0;
      scalar_rs2_i       = '0;
      port_group_ready_i = '0;
      load_stimulus();
      cycle_limit = steps.size() * (HAZARD_CYCLES + 4) + 50;
      repeat (5) @(negedge clk);
      rstn = 1'b1;
      #1;
      check_value(instr_rdy_o, 1'b1, "instr_rdy_o after reset");
      check_value(start_o, '0, "start_o after reset");
      check_value(vl_o, VLEN / 32, "vl_o after reset");
      check_value(sew_o, 3'd2, "sew_o after reset");   // 32-bit elements
      check_value(lmul_o, 3'd0, "lmul_o after reset");
      foreach (steps[i])
      begin
         if (steps[i].cls[2:0] == 3'd5)
         begin
            run_config_step(steps[i]);
         end
         else
         begin
            run_arith_step(steps[i]);
         end
      end
      if (fail_count == 0)
      begin
         $display("ALL TESTS PASSED");
      end
      else
      begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
hw/vcu_pkg.sv
hw/vcu_issue_if.sv
hw/instr_capture.sv
hw/vtype_config.sv
hw/alu_op_decoder.sv
hw/port_allocator.sv
hw/hazard_tracker.sv
hw/vcu_top.sv
testbench/tb_vcu.sv

/* testbench/vcu_stimulus.txt */
# class instr rs1 ready delay exp_a exp_b exp_c wait, all hex; class 0 vv 1 vi 2 vx 3 mvv 4 mvx 5 cfg
# cfg rows expect sew lmul vl, arithmetic rows expect opmode op2_sel start
# vsetvli, vl from vlmax, from rs1, fractional lmul, kept vl
5 00A070D7 00000000 F 0 1 2 400 0
5 0401F157 00000025 F 0 0 0 25 0
5 016071D7 00000000 F 0 2 6 20 0
5 01F07057 12345678 F 0 3 7 20 0
# vsetvl, vtype from rs1
5 80007257 00000005 F 0 0 5 40 0
5 01B072D7 00000000 F 0 3 3 200 0
# arithmetic, lowest ready group and no-ready back-pressure
0 023100D7 DEADBEEF F 0 040 0 1 0
1 9642B357 11111111 C 0 100 2 4 0
2 2E74C457 CAFEF00D 2 3 0C2 1 2 3
# vs1 reads the vd just launched
3 96A425D7 00000000 F 0 140 0 1 E
4 A6C0E6D7 00000042 2 0 180 1 2 0
# vs2 reads a vd from two launches back
0 62B707D7 00000000 F 0 086 0 1 C
2 0B07C8D7 7FFFFFFF F 0 042 1 1 0
3 43392A57 00000000 8 0 000 0 8 0
1 A75FBB57 00000000 6 0 102 2 2 0
4 9361EBD7 0000ABCD F 0 144 1 1 E
# config after arithmetic
5 011170D7 00000080 F 0 2 1 80 0
